/* hw/du_bp_match.sv */
`timescale 1ns/10ps

// Breakpoint comparators
// Fetch PC and data address matching per slot,
// plus single step and branch trapping on fetch

module du_bp_match (
  // Slot configuration
  input  logic [du_map_pkg::MAX_BREAKPOINTS-1:0]               bp_enabled,
  input  du_cpu_pkg::bp_cc_e [du_map_pkg::MAX_BREAKPOINTS-1:0] bp_cc,
  input  logic [du_map_pkg::MAX_BREAKPOINTS-1:0][du_map_pkg::XLEN-1:0] bp_data,
  input  logic                                    instr_break_ena,
  input  logic                                    branch_break_ena,
  // Fetch stage
  input  logic [du_map_pkg::XLEN-1:0]             if_pc,
  input  logic [du_cpu_pkg::ILEN-1:0]             if_instr,
  input  logic                                    if_bubble,
  // Memory stage
  input  logic [du_cpu_pkg::ILEN-1:0]             mem_instr,
  input  logic                                    mem_bubble,
  input  logic [du_cpu_pkg::EXCEPTION_SIZE-1:0]   mem_exception,
  input  logic [du_map_pkg::XLEN-1:0]             mem_memadr,
  input  logic                                    dmem_ack,
  input  logic                                    bu_flush,
  input  logic                                    st_flush,
  // Hits
  output logic [du_map_pkg::MAX_BREAKPOINTS-1:0]  bp_hit,
  output logic                                    instr_hit,
  output logic                                    branch_hit
);

  import du_map_pkg::*;
  import du_cpu_pkg::*;

  logic mem_ok;
  logic mem_read;
  logic mem_write;
  logic fetch_ok;

  // Only clean memory stage accesses qualify
  assign mem_ok    = ~(|mem_exception) & ~mem_bubble;
  assign mem_read  = mem_ok & (mem_instr[6:2] == OPC_LOAD);
  assign mem_write = mem_ok & (mem_instr[6:2] == OPC_STORE);

  // Fetch PC is stale during a flush
  assign fetch_ok  = ~bu_flush & ~st_flush;

  //////////////////////////////
  // Slot comparators
  //////////////////////////////

  always_comb begin
    for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
      bp_hit[n] = 1'b0;
      if (bp_enabled[n]) begin
        case (bp_cc[n])
          CC_FETCH:    bp_hit[n] = (if_pc == bp_data[n]) & fetch_ok;
          CC_LD_ADR:   bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & mem_read;
          CC_ST_ADR:   bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack & mem_write;
          CC_LDST_ADR: bp_hit[n] = (mem_memadr == bp_data[n]) & dmem_ack &
                                   (mem_read | mem_write);
          default:     bp_hit[n] = 1'b0;
        endcase
      end
    end
  end

  //////////////////////////////
  // Instruction and branch
  //////////////////////////////

  // Every real fetch when stepping
  assign instr_hit  = instr_break_ena & ~if_bubble;
  assign branch_hit = branch_break_ena & ~if_bubble & (if_instr[6:2] == OPC_BRANCH);

  // Disabled slots stay silent
  always_comb begin
    a_hit_needs_enable : assert final ((bp_hit & ~bp_enabled) == '0);
  end

endmodule

/* hw/du_cpu_pkg.sv */
// CPU side definitions for the debug unit
// Instruction opcodes, breakpoint conditions
// and exception vector layout

package du_cpu_pkg;

  //////////////////////////////
  // Instruction fields
  //////////////////////////////

  // Instruction word width
  localparam int ILEN = 32;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'h00,
    OPC_STORE  = 5'h08,
    OPC_BRANCH = 5'h18
  } rv_opcode_e;

  //////////////////////////////
  // Breakpoint conditions
  //////////////////////////////

  // BPCTRL bits 6:4
  // Codes 4 to 7 never hit
  typedef enum logic [2:0] {
    CC_FETCH    = 3'd0,
    CC_LD_ADR   = 3'd1,
    CC_ST_ADR   = 3'd2,
    CC_LDST_ADR = 3'd3
  } bp_cc_e;

  //////////////////////////////
  // Exceptions
  //////////////////////////////

  // Memory stage exception vector
  localparam int EXCEPTION_SIZE = 16;

  // Set in CAUSE for interrupts
  localparam int CAUSE_INT_BIT = du_map_pkg::XLEN - 1;

endpackage

/* hw/du_map_pkg.sv */
// Debug unit address map
// Bank decoding, register offsets and data widths
// shared by the debugger port and the register bank

package du_map_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Data path
  localparam int XLEN = 32;

  // Debug address
  localparam int PLEN = 32;

  // Offset inside one bank
  localparam int DU_ADDR_SIZE = 12;

  // Upper address bits select the bank
  // Only the internal bank is mapped
  typedef enum logic [PLEN-DU_ADDR_SIZE-1:0] {
    DBG_INTERNAL = '0
  } du_bank_e;

  //////////////////////////////
  // Internal bank offsets
  //////////////////////////////

  localparam logic [DU_ADDR_SIZE-1:0] DBG_CTRL    = 12'h000;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_HIT     = 12'h001;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_IE      = 12'h002;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_CAUSE   = 12'h003;

  // Slot n control at BPCTRL0 + 2n, data right above it
  localparam logic [DU_ADDR_SIZE-1:0] DBG_BPCTRL0 = 12'h010;
  localparam logic [DU_ADDR_SIZE-1:0] DBG_BPDATA0 = 12'h011;

  //////////////////////////////
  // Breakpoint slots
  //////////////////////////////

  // Address space reserved for slots
  localparam int MAX_BREAKPOINTS = 8;

  // Slots backed by hardware
  localparam int BREAKPOINTS = 3;

  // Slot 0 position in DBG_HIT
  localparam int HIT_BP_LSB = 4;

endpackage

/* hw/du_port_access.sv */
`timescale 1ns/10ps

// Debugger port front end
// Decodes the bank, turns a strobe into a one-cycle write command
// and paces the ack through a three-stage shift chain.
// Also drives the CPU stall and flush controls

module du_port_access (
  input  logic                                clk,
  input  logic                                rstn,
  // Debugger side
  input  logic                                dbg_strb,
  input  logic                                dbg_we,
  input  logic [du_map_pkg::PLEN-1:0]         dbg_addr,
  input  logic [du_map_pkg::XLEN-1:0]         dbg_dati,
  input  logic                                dbg_stall,
  output logic                                dbg_ack,
  // CPU side
  input  logic                                ex_stall,
  input  logic [31:0]                         du_exceptions,
  output logic                                du_stall,
  output logic                                du_stall_dly,
  output logic                                du_flush,
  // Write command to the register bank
  output logic                                wr_pulse,
  output logic [du_map_pkg::DU_ADDR_SIZE-1:0] reg_addr,
  output logic [du_map_pkg::XLEN-1:0]         reg_wdata
);

  import du_map_pkg::*;

  du_bank_e   bank;
  logic       du_access;
  logic       strb_dly;
  logic       strb_first;
  logic [2:0] ack_sr;

  //////////////////////////////
  // Access decode
  //////////////////////////////

  // Unmapped banks never start an access
  assign bank      = du_bank_e'(dbg_addr[PLEN-1:DU_ADDR_SIZE]);
  assign du_access = dbg_strb & (bank == DBG_INTERNAL);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      strb_dly <= 1'b0;
    end else begin
      strb_dly <= dbg_strb;
    end
  end

  // First cycle of a strobe
  assign strb_first = du_access & ~strb_dly;

  // Ack chain, frozen while EX stalls
  // Fills from the top, ack pops out of bit 0
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_sr <= '0;
    end else if (!ex_stall) begin
      ack_sr <= {3{du_access & ~dbg_ack}} & {1'b1, ack_sr[2:1]};
    end
  end

  assign dbg_ack = ack_sr[0];

  // Write command, one cycle behind the strobe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_pulse <= 1'b0;
    end else begin
      wr_pulse <= strb_first & dbg_we;
    end
  end

  // Offset also steers the read mux
  always_ff @(posedge clk) begin
    if (du_access) begin
      reg_addr  <= dbg_addr[DU_ADDR_SIZE-1:0];
      reg_wdata <= dbg_dati;
    end
  end

  //////////////////////////////
  // Stall and flush
  //////////////////////////////

  assign du_stall = dbg_stall;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      du_stall_dly <= 1'b0;
    end else begin
      du_stall_dly <= dbg_stall;
    end
  end

  // Pulse on stall release with an exception pending
  assign du_flush = du_stall_dly & ~dbg_stall & (|du_exceptions);

  // Debugger must see separate acks
  a_ack_single : assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack |=> !dbg_ack);

endmodule

/* hw/du_regs.sv */
`timescale 1ns/10ps

// Debug unit internal register bank
// Control, sticky hit flags, interrupt enable, trap cause
// and breakpoint slots, plus the read mux and the
// registered breakpoint request to the core

module du_regs (
  input  logic                                          clk,
  input  logic                                          rstn,
  // Write command and read select
  input  logic                                          wr_pulse,
  input  logic [du_map_pkg::DU_ADDR_SIZE-1:0]           reg_addr,
  input  logic [du_map_pkg::XLEN-1:0]                   reg_wdata,
  output logic [du_map_pkg::XLEN-1:0]                   dbg_dato,
  // CPU status
  input  logic [31:0]                                   du_exceptions,
  input  logic                                          du_stall,
  input  logic                                          du_flush,
  input  logic                                          ex_stall,
  input  logic                                          bu_flush,
  input  logic                                          st_flush,
  output logic                                          dbg_bp,
  output logic [31:0]                                   du_ie,
  // Breakpoint slot configuration
  output logic [du_map_pkg::MAX_BREAKPOINTS-1:0]        bp_enabled,
  output du_cpu_pkg::bp_cc_e [du_map_pkg::MAX_BREAKPOINTS-1:0] bp_cc,
  output logic [du_map_pkg::MAX_BREAKPOINTS-1:0][du_map_pkg::XLEN-1:0] bp_data,
  output logic                                          instr_break_ena,
  output logic                                          branch_break_ena,
  // Hits from the comparators
  input  logic [du_map_pkg::MAX_BREAKPOINTS-1:0]        bp_hit,
  input  logic                                          instr_hit,
  input  logic                                          branch_hit
);

  import du_map_pkg::*;
  import du_cpu_pkg::*;

  logic [MAX_BREAKPOINTS-1:0] bp_impl;
  logic [MAX_BREAKPOINTS-1:0] bp_flag;
  logic                       instr_flag;
  logic                       branch_flag;
  logic [XLEN-1:0]            cause;
  logic [XLEN-1:0]            exc_cause;
  logic [3:0]                 trap_idx;
  logic [3:0]                 int_idx;
  logic [XLEN-1:0]            rd_data;
  logic                       wr_unimpl;

  // Slots with hardware behind them
  always_comb begin
    for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
      bp_impl[n] = (n < BREAKPOINTS);
    end
  end

  //////////////////////////////
  // CTRL and IE
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_break_ena  <= 1'b0;
      branch_break_ena <= 1'b0;
      du_ie            <= '0;
    end else if (wr_pulse) begin
      if (reg_addr == DBG_CTRL) begin
        instr_break_ena  <= reg_wdata[0];
        branch_break_ena <= reg_wdata[1];
      end
      if (reg_addr == DBG_IE) begin
        du_ie <= reg_wdata[31:0];
      end
    end
  end

  //////////////////////////////
  // Sticky hit flags
  //////////////////////////////

  // Debugger write replaces, otherwise hits accumulate
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      instr_flag  <= 1'b0;
      branch_flag <= 1'b0;
      bp_flag     <= '0;
    end else if (wr_pulse && reg_addr == DBG_HIT) begin
      instr_flag  <= reg_wdata[0];
      branch_flag <= reg_wdata[1];
      bp_flag     <= reg_wdata[HIT_BP_LSB +: MAX_BREAKPOINTS] & bp_impl;
    end else begin
      instr_flag  <= instr_flag | instr_hit;
      branch_flag <= branch_flag | branch_hit;
      bp_flag     <= bp_flag | (bp_hit & bp_impl);
    end
  end

  //////////////////////////////
  // Cause encoder
  //////////////////////////////

  // Lowest set bit wins, scan from the top
  always_comb begin
    trap_idx = '0;
    int_idx  = '0;
    for (int k = 15; k >= 0; k--) begin
      if (du_exceptions[k]) trap_idx = 4'(k);
      if (du_exceptions[16+k]) int_idx = 4'(k);
    end
    // Traps take priority over interrupts
    exc_cause = '0;
    if (|du_exceptions[15:0]) begin
      exc_cause[3:0] = trap_idx;
    end else begin
      exc_cause[CAUSE_INT_BIT] = 1'b1;
      exc_cause[3:0]           = int_idx;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cause <= '0;
    end else if (wr_pulse && reg_addr == DBG_CAUSE) begin
      cause <= reg_wdata;
    end else if (|du_exceptions) begin
      cause <= exc_cause;
    end
  end

  //////////////////////////////
  // Breakpoint slots
  //////////////////////////////

  // Unimplemented slots stay in reset
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bp_enabled <= '0;
      bp_data    <= '0;
      for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
        bp_cc[n] <= CC_FETCH;
      end
    end else if (wr_pulse) begin
      for (int n = 0; n < BREAKPOINTS; n++) begin
        if (reg_addr == DU_ADDR_SIZE'(DBG_BPCTRL0 + 2*n)) begin
          bp_enabled[n] <= reg_wdata[1];
          bp_cc[n]      <= bp_cc_e'(reg_wdata[6:4]);
        end
        if (reg_addr == DU_ADDR_SIZE'(DBG_BPDATA0 + 2*n)) begin
          bp_data[n] <= reg_wdata;
        end
      end
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    rd_data = '0;
    case (reg_addr)
      DBG_CTRL:  rd_data[1:0] = {branch_break_ena, instr_break_ena};
      DBG_HIT: begin
        rd_data[HIT_BP_LSB +: MAX_BREAKPOINTS] = bp_flag;
        rd_data[1:0]                           = {branch_flag, instr_flag};
      end
      DBG_IE:    rd_data[31:0] = du_ie;
      DBG_CAUSE: rd_data       = cause;
      default: begin
        // Slot registers, anything else reads zero
        for (int n = 0; n < MAX_BREAKPOINTS; n++) begin
          if (reg_addr == DU_ADDR_SIZE'(DBG_BPCTRL0 + 2*n)) begin
            rd_data[6:4] = bp_cc[n];
            rd_data[1]   = bp_enabled[n];
            rd_data[0]   = bp_impl[n];
          end
          if (reg_addr == DU_ADDR_SIZE'(DBG_BPDATA0 + 2*n)) begin
            rd_data = bp_data[n];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    dbg_dato <= rd_data;
  end

  // Break request to the core
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dbg_bp <= 1'b0;
    end else begin
      dbg_bp <= ~ex_stall & ~du_stall & ~du_flush & ~bu_flush & ~st_flush &
                ((|du_exceptions) | (|bp_flag) | instr_flag | branch_flag);
    end
  end

  // Writes into the unimplemented slot range
  assign wr_unimpl = wr_pulse &&
                     reg_addr >= DU_ADDR_SIZE'(DBG_BPCTRL0 + 2*BREAKPOINTS) &&
                     reg_addr <  DU_ADDR_SIZE'(DBG_BPCTRL0 + 2*MAX_BREAKPOINTS);

  a_unimpl_slot_ro : assert property (@(posedge clk) disable iff (!rstn)
    wr_unimpl |=> $stable(bp_enabled[MAX_BREAKPOINTS-1:BREAKPOINTS]) &&
                  $stable(bp_cc[MAX_BREAKPOINTS-1:BREAKPOINTS]) &&
                  $stable(bp_data[MAX_BREAKPOINTS-1:BREAKPOINTS]));

endmodule

/* hw/riscv_du.sv */
`timescale 1ns/10ps

// RISC-V core debug unit
// Port front end, internal register bank and breakpoint
// comparators, connected by name

module riscv_du (
  input  logic                                  clk,
  input  logic                                  rstn,
  // Debugger port
  input  logic                                  dbg_strb,
  input  logic                                  dbg_we,
  input  logic [du_map_pkg::PLEN-1:0]           dbg_addr,
  input  logic [du_map_pkg::XLEN-1:0]           dbg_dati,
  input  logic                                  dbg_stall,
  output logic [du_map_pkg::XLEN-1:0]           dbg_dato,
  output logic                                  dbg_ack,
  output logic                                  dbg_bp,
  // CPU controls
  output logic                                  du_stall,
  output logic                                  du_stall_dly,
  output logic                                  du_flush,
  output logic [31:0]                           du_ie,
  input  logic [31:0]                           du_exceptions,
  input  logic                                  ex_stall,
  input  logic                                  bu_flush,
  input  logic                                  st_flush,
  // Pipeline observation
  input  logic [du_map_pkg::XLEN-1:0]           if_pc,
  input  logic [du_cpu_pkg::ILEN-1:0]           if_instr,
  input  logic                                  if_bubble,
  input  logic [du_cpu_pkg::ILEN-1:0]           mem_instr,
  input  logic                                  mem_bubble,
  input  logic [du_cpu_pkg::EXCEPTION_SIZE-1:0] mem_exception,
  input  logic [du_map_pkg::XLEN-1:0]           mem_memadr,
  input  logic                                  dmem_ack
);

  import du_map_pkg::*;
  import du_cpu_pkg::*;

  // Write command
  logic                       wr_pulse;
  logic [DU_ADDR_SIZE-1:0]    reg_addr;
  logic [XLEN-1:0]            reg_wdata;

  // Slot configuration
  logic [MAX_BREAKPOINTS-1:0] bp_enabled;
  bp_cc_e [MAX_BREAKPOINTS-1:0] bp_cc;
  logic [MAX_BREAKPOINTS-1:0][XLEN-1:0] bp_data;
  logic                       instr_break_ena;
  logic                       branch_break_ena;

  // Hits back to the register bank
  logic [MAX_BREAKPOINTS-1:0] bp_hit;
  logic                       instr_hit;
  logic                       branch_hit;

  du_port_access i_port_access (.*);

  du_regs i_regs (.*);

  du_bp_match i_bp_match (.*);

endmodule

/* riscv_du.f */
hw/du_map_pkg.sv
hw/du_cpu_pkg.sv
hw/du_port_access.sv
hw/du_regs.sv
hw/du_bp_match.sv
hw/riscv_du.sv
sim/du_checker.sv
sim/riscv_du_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module riscv_du_tb \
  --Mdir obj_dir \
  -f riscv_du.f

./obj_dir/Vriscv_du_tb | tee sim.log

if grep -q "^all tests passed$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

/* sim/du_checker.sv */
`timescale 1ns/10ps

// Result checker for the debug unit testbench
// Compares expected values with the DUT ports,
// watches dbg_ack for single-cycle pulses and keeps the counts

module du_checker (
  input logic        clk,
  input logic        rstn,
  input logic        dbg_ack,
  input logic        dbg_bp,
  input logic [31:0] dbg_dato,
  input logic [31:0] du_ie,
  input logic        du_stall,
  input logic        du_stall_dly,
  input logic        du_flush
);

  int   checks     = 0;
  int   errors     = 0;
  int   ack_errors = 0;
  int   timeouts   = 0;
  logic ack_q      = 1'b0;

  //////////////////////////////
  // Compare helpers
  //////////////////////////////

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Picks the DUT port by name
  task automatic check_port(input string name, input logic [31:0] exp);
    if (name == "dbg_ack")
      compare(name, exp, {31'b0, dbg_ack});
    else if (name == "dbg_bp")
      compare(name, exp, {31'b0, dbg_bp});
    else if (name == "dbg_dato")
      compare(name, exp, dbg_dato);
    else if (name == "du_ie")
      compare(name, exp, du_ie);
    else if (name == "du_stall")
      compare(name, exp, {31'b0, du_stall});
    else if (name == "du_stall_dly")
      compare(name, exp, {31'b0, du_stall_dly});
    else if (name == "du_flush")
      compare(name, exp, {31'b0, du_flush});
    else begin
      errors++;
      $display("Checker was asked about an unknown signal %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Problem at %0t: %s", $time, what);
  endtask

  // Ack is a one-cycle pulse
  always @(negedge clk) begin
    if (rstn && dbg_ack && ack_q) begin
      ack_errors++;
      $display("dbg_ack stayed high for two cycles at %0t", $time);
    end
    ack_q <= dbg_ack;
  end

  function automatic int failures();
    return errors + ack_errors + timeouts;
  endfunction

  task automatic print_counts();
    $display("checks %0d, value errors %0d, ack errors %0d, timeouts %0d",
             checks, errors, ack_errors, timeouts);
  endtask

endmodule

/* sim/riscv_du_tb.sv */
`timescale 1ns/10ps

// Testbench for the RISC-V debug unit
// Register read-back from a stimulus table, ack timing,
// breakpoints, cause encoding and flush

module riscv_du_tb;

  import du_map_pkg::*;
  import du_cpu_pkg::*;

  localparam int          ACK_LIMIT = 20;
  localparam logic [31:0] IDLE_PC   = 32'h0000_0002;
  localparam logic [31:0] NOP       = 32'h0000_0013;

  // One table row with expected read data
  typedef struct packed {
    logic        we;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
  } access_t;

  logic        clk;
  logic        rstn;
  logic        dbg_strb;
  logic        dbg_we;
  logic [31:0] dbg_addr;
  logic [31:0] dbg_dati;
  logic        dbg_stall;
  logic [31:0] dbg_dato;
  logic        dbg_ack;
  logic        dbg_bp;
  logic        du_stall;
  logic        du_stall_dly;
  logic        du_flush;
  logic [31:0] du_ie;
  logic [31:0] du_exceptions;
  logic        ex_stall;
  logic        bu_flush;
  logic        st_flush;
  logic [31:0] if_pc;
  logic [31:0] if_instr;
  logic        if_bubble;
  logic [31:0] mem_instr;
  logic        mem_bubble;
  logic [15:0] mem_exception;
  logic [31:0] mem_memadr;
  logic        dmem_ack;

  access_t     stim[$];
  int          lat;
  int          k;
  int          flush_cycles;
  logic [31:0] rnd;
  logic [31:0] ie_val;
  logic [31:0] bp_adr;

  riscv_du i_riscv_du (.*);

  du_checker i_checker (.*);

  always #10 clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Write row followed by a read-back row
  function automatic void add_pair(input logic [11:0] offs, input logic [31:0] wdata,
                                   input logic [31:0] rdata);
    access_t e;
    e.we    = 1'b1;
    e.addr  = offs;
    e.wdata = wdata;
    e.rdata = '0;
    stim.push_back(e);
    e.we    = 1'b0;
    e.wdata = '0;
    e.rdata = rdata;
    stim.push_back(e);
  endfunction

  // One debugger access that counts clocks up to the ack
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp, input int limit, input logic want_ack,
                            output int edges);
    logic seen;
    edges = 0;
    seen  = 1'b0;
    @(posedge clk);
    dbg_strb <= 1'b1;
    dbg_we   <= we;
    dbg_addr <= addr;
    dbg_dati <= wdata;
    while (!seen && edges < limit) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      seen = dbg_ack;
    end
    // Read data valid only with ack
    if (seen && !we)
      i_checker.check_port("dbg_dato", exp);
    if (want_ack && !seen)
      i_checker.report_timeout($sformatf("ack at address %h", addr));
    if (!want_ack && seen)
      i_checker.report_problem($sformatf("unmapped address %h was acknowledged", addr));
    @(posedge clk);
    dbg_strb <= 1'b0;
    dbg_we   <= 1'b0;
    @(negedge clk);
    i_checker.check_port("dbg_ack", 32'h0);
  endtask

  task automatic write_reg(input logic [11:0] offs, input logic [31:0] data);
    bus_access(1'b1, {20'h0, offs}, data, '0, ACK_LIMIT, 1'b1, lat);
  endtask

  task automatic read_check(input logic [11:0] offs, input logic [31:0] exp);
    bus_access(1'b0, {20'h0, offs}, '0, exp, ACK_LIMIT, 1'b1, lat);
  endtask

  // Single fetch followed by a bubble
  task automatic fetch_pulse(input logic [31:0] pc, input logic [31:0] instr);
    @(posedge clk);
    if_pc     <= pc;
    if_instr  <= instr;
    if_bubble <= 1'b0;
    @(posedge clk);
    if_pc     <= IDLE_PC;
    if_instr  <= NOP;
    if_bubble <= 1'b1;
  endtask

  // One memory stage access with dmem_ack
  task automatic mem_pulse(input logic [31:0] instr, input logic bubble, input logic [31:0] adr);
    @(posedge clk);
    mem_instr  <= instr;
    mem_bubble <= bubble;
    mem_memadr <= adr;
    dmem_ack   <= 1'b1;
    @(posedge clk);
    mem_instr  <= NOP;
    mem_bubble <= 1'b0;
    mem_memadr <= '0;
    dmem_ack   <= 1'b0;
  endtask

  task automatic exc_pulse(input logic [31:0] vec);
    @(posedge clk);
    du_exceptions <= vec;
    @(posedge clk);
    du_exceptions <= '0;
  endtask

  task automatic wait_bp(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!dbg_bp && n < ACK_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!dbg_bp)
      i_checker.report_timeout(what);
  endtask

  // Hard limit on the whole run
  initial begin
    #200_000;
    $display("Simulation ran past its time limit");
    $display("tests failed");
    $finish;
  end

  initial begin
    clk           = 1'b0;
    rstn          = 1'b0;
    dbg_strb      = 1'b0;
    dbg_we        = 1'b0;
    dbg_addr      = '0;
    dbg_dati      = '0;
    dbg_stall     = 1'b0;
    du_exceptions = '0;
    ex_stall      = 1'b0;
    bu_flush      = 1'b0;
    st_flush      = 1'b0;
    if_pc         = IDLE_PC;
    if_instr      = NOP;
    if_bubble     = 1'b1;
    mem_instr     = NOP;
    mem_bubble    = 1'b0;
    mem_exception = '0;
    mem_memadr    = '0;
    dmem_ack      = 1'b0;
    rnd           = $urandom(32'hf4a4_6c4b);

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    rnd = $urandom();
    add_pair(DBG_CTRL, rnd, rnd & 32'h3);
    ie_val = $urandom();
    add_pair(DBG_IE, ie_val, ie_val);
    rnd = $urandom();
    add_pair(DBG_CAUSE, rnd, rnd);
    // Data before control so a fresh slot never matches
    for (k = 0; k < MAX_BREAKPOINTS; k++) begin
      rnd = $urandom();
      add_pair(12'(DBG_BPDATA0 + 2*k), rnd, (k < 3) ? rnd : 32'h0);
      rnd = $urandom();
      add_pair(12'(DBG_BPCTRL0 + 2*k), rnd, (k < 3) ? ((rnd & 32'h72) | 32'h1) : 32'h0);
    end
    add_pair(12'h7ff, $urandom(), 32'h0);
    add_pair(12'h004, $urandom(), 32'h0);
    // Clean state for later scenarios
    add_pair(DBG_CTRL, 32'h0, 32'h0);
    for (k = 0; k < 3; k++)
      add_pair(12'(DBG_BPCTRL0 + 2*k), 32'h0, 32'h1);
    add_pair(DBG_HIT, 32'h0, 32'h0);

    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    i_checker.check_port("dbg_ack", 32'h0);
    i_checker.check_port("dbg_bp", 32'h0);
    i_checker.check_port("du_ie", 32'h0);
    i_checker.check_port("du_stall_dly", 32'h0);

    foreach (stim[i])
      bus_access(stim[i].we, {20'h0, stim[i].addr}, stim[i].wdata, stim[i].rdata,
                 ACK_LIMIT, 1'b1, lat);

    // IE drives the core enables directly
    i_checker.check_port("du_ie", ie_val);

    //////////////////////////////
    // Ack timing
    //////////////////////////////

    read_check(DBG_CTRL, 32'h0);
    i_checker.compare("ack latency", 32'd3, lat);
    k = int'($urandom_range(4, 1));
    fork
      bus_access(1'b0, {20'h0, DBG_CTRL}, '0, '0, ACK_LIMIT, 1'b1, lat);
      begin
        repeat (2) @(posedge clk);
        ex_stall <= 1'b1;
        repeat (k) @(posedge clk);
        ex_stall <= 1'b0;
      end
    join
    i_checker.compare("ack latency with ex_stall", 32'(3 + k), lat);
    // Bank 1 is unmapped
    bus_access(1'b0, 32'h0000_1000, '0, '0, 10, 1'b0, lat);

    //////////////////////////////
    // Fetch and address slots
    //////////////////////////////

    bp_adr = $urandom() & 32'hffff_fffc;
    write_reg(DBG_BPDATA0, bp_adr);
    write_reg(DBG_BPCTRL0, {25'h0, CC_FETCH, 4'h2});
    fetch_pulse(bp_adr, NOP);
    wait_bp("dbg_bp after a fetch breakpoint");
    read_check(DBG_HIT, 32'h10);
    write_reg(DBG_HIT, 32'h0);
    read_check(DBG_HIT, 32'h0);
    i_checker.check_port("dbg_bp", 32'h0);
    write_reg(DBG_BPCTRL0, 32'h0);

    bp_adr = $urandom() & 32'hffff_fffc;
    write_reg(12'(DBG_BPDATA0 + 2), bp_adr);
    write_reg(12'(DBG_BPCTRL0 + 2), {25'h0, CC_ST_ADR, 4'h2});
    mem_pulse({25'h0, OPC_LOAD, 2'b11}, 1'b0, bp_adr);
    read_check(DBG_HIT, 32'h0);
    mem_pulse({25'h0, OPC_STORE, 2'b11}, 1'b1, bp_adr);
    read_check(DBG_HIT, 32'h0);
    mem_pulse({25'h0, OPC_STORE, 2'b11}, 1'b0, bp_adr);
    read_check(DBG_HIT, 32'h20);
    write_reg(12'(DBG_BPCTRL0 + 2), 32'h0);
    write_reg(DBG_HIT, 32'h0);

    //////////////////////////////
    // Instruction and branch
    //////////////////////////////

    write_reg(DBG_CTRL, 32'h3);
    fetch_pulse(IDLE_PC, NOP);
    read_check(DBG_HIT, 32'h1);
    write_reg(DBG_HIT, 32'h0);
    fetch_pulse(IDLE_PC, {25'h0, OPC_BRANCH, 2'b11});
    read_check(DBG_HIT, 32'h3);
    write_reg(DBG_CTRL, 32'h0);
    write_reg(DBG_HIT, 32'h0);

    //////////////////////////////
    // Cause and flush
    //////////////////////////////

    k = int'($urandom_range(15, 0));
    exc_pulse(32'h1 << k);
    read_check(DBG_CAUSE, 32'(k));
    k = int'($urandom_range(15, 0));
    exc_pulse(32'h1 << (16 + k));
    read_check(DBG_CAUSE, 32'h8000_0000 | 32'(k));
    // Lowest trap bit is 9
    exc_pulse(32'h0005_1200);
    read_check(DBG_CAUSE, 32'd9);

    @(posedge clk);
    du_exceptions <= 32'h0000_0004;
    dbg_stall     <= 1'b1;
    // Stall passes straight through, the delayed copy follows a cycle later
    @(negedge clk);
    i_checker.check_port("du_stall", 32'h1);
    i_checker.check_port("du_stall_dly", 32'h0);
    @(negedge clk);
    i_checker.check_port("du_stall_dly", 32'h1);
    i_checker.check_port("du_flush", 32'h0);
    repeat (2) @(posedge clk);
    dbg_stall <= 1'b0;
    @(negedge clk);
    i_checker.check_port("du_stall", 32'h0);
    flush_cycles = du_flush ? 1 : 0;
    repeat (5) begin
      @(negedge clk);
      if (du_flush)
        flush_cycles++;
    end
    i_checker.compare("du_flush cycles", 32'd1, 32'(flush_cycles));
    @(posedge clk);
    du_exceptions <= '0;
    repeat (2) @(posedge clk);

    i_checker.print_counts();
    if (i_checker.failures() == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
